//--- verilog.f
+incdir+.
spl_csr_pkg.sv
spl_mem_pkg.sv
csr_file.sv
base_writer.sv
wr_arbiter.sv
spl_top.sv
tb_spl_top.sv

//--- Makefile
TOP = tb_spl_top

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf obj_dir

//--- tb_spl_top.sv
`include "spl_settings.svh"

module tb_spl_top
    import spl_csr_pkg::*;
    import spl_mem_pkg::*;
();

    localparam logic [31:0] SEED = 32'h0fbd20b0;

    logic        clk = 1'b0;
    logic        reset_n;
    csr_wr_t     csr_wr;
    logic        spl_reset;
    logic        spl_enable;
    logic        mem_wr_valid;
    mem_wr_req_t mem_wr;
    logic        credit_ret = 1'b0;

    logic        credit_hold;
    logic [31:0] stim_rng = SEED;
    logic [31:0] ret_rng = ~SEED;
    int          ret_wait = 0;
    int          sent_cnt = 0;
    int          ret_cnt = 0;
    mem_wr_req_t spl_q[$];
    mem_wr_req_t afu_q[$];
    mem_wr_req_t ctx_q[$];

    // Mirror of the register map
    logic [5:0]  m_spl_hi = '0;
    logic [5:0]  m_afu_hi = '0;
    logic [5:0]  m_ctx_hi = '0;
    logic [31:0] m_spl_scratch = '0;
    logic [31:0] m_afu_scratch = '0;
    logic [31:0] m_opcode = '0;
    logic        m_enable = 1'b0;
    logic [7:0]  m_dsm_cnt = '0;
    logic [31:0] m_ctx_seq = '0;

    spl_top dut0 (
        .clk          (clk),
        .reset_n      (reset_n),
        .csr_wr       (csr_wr),
        .spl_reset    (spl_reset),
        .spl_enable   (spl_enable),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr       (mem_wr),
        .credit_ret   (credit_ret)
    );

    always #2 clk = ~clk;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] rand_word();
        stim_rng = lcg_step(stim_rng);
        return stim_rng;
    endfunction

    // Expected memory write for a base completed with the current register values
    function automatic mem_wr_req_t ref_req(input mem_src_e src, input logic [5:0] hi,
                                            input logic [31:0] data);
        mem_wr_req_t  r;
        spl_dsm_rec_t s;
        afu_dsm_rec_t a;
        ctx_hdr_rec_t c;
        s.rsvd       = '0;
        s.enable     = m_enable;
        s.prog_count = m_dsm_cnt;
        s.scratch    = m_spl_scratch;
        a.opcode     = m_opcode;
        a.scratch    = m_afu_scratch;
        c.rsvd       = '0;
        c.enable     = m_enable;
        c.seq_count  = m_ctx_seq;
        r.addr = {hi, data[31:6]};  // Cache-line address from six high bits and the low word
        r.src  = src;
        case (src)
            SRC_SPL_DSM: r.data = s;
            SRC_AFU_DSM: r.data = a;
            default:     r.data = c;
        endcase
        return r;
    endfunction

    task automatic fail_with(input string what);
        $display("%s at time %0t", what, $time);
        $display("test failed");
        $fatal(1, "%s", what);
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, name, got, exp);
            $display("test failed");
            $fatal(1, "%s mismatch", name);
        end
    endtask

    task automatic model_write(input logic [7:0] group, input logic [5:0] offset,
                               input logic [31:0] data);
        if (group == `SPL_CSR_GROUP) begin
            case (offset)
                `SPL_DSM_BASEH: m_spl_hi = data[5:0];
                `SPL_CTX_BASEH: m_ctx_hi = data[5:0];
                `SPL_SCRATCH:   m_spl_scratch = data;
                `SPL_CTRL:      m_enable = data[1];
                `SPL_DSM_BASEL: begin
                    m_dsm_cnt = m_dsm_cnt + 8'd1;
                    spl_q.push_back(ref_req(SRC_SPL_DSM, m_spl_hi, data));
                    m_spl_hi = '0;  // DSM high half is consumed by the handover
                end
                `SPL_CTX_BASEL: begin
                    m_ctx_seq = m_ctx_seq + 32'd1;
                    ctx_q.push_back(ref_req(SRC_CTX, m_ctx_hi, data));
                end
                default: ;
            endcase
        end else if (group == `AFU_CSR_GROUP) begin
            case (offset)
                `AFU_DSM_BASEH:  m_afu_hi = data[5:0];
                `AFU_CMD_OPCODE: m_opcode = data;
                `AFU_SCRATCH:    m_afu_scratch = data;
                `AFU_DSM_BASEL: begin
                    afu_q.push_back(ref_req(SRC_AFU_DSM, m_afu_hi, data));
                    m_afu_hi = '0;
                end
                default: ;
            endcase
        end
    endtask

    // One write per call followed by an idle cycle
    task automatic csr_write(input logic [7:0] group, input logic [5:0] offset,
                             input logic [31:0] data);
        @(negedge clk);
        csr_wr.valid = 1'b1;
        csr_wr.addr  = {group, offset};
        csr_wr.data  = data;
        model_write(group, offset, data);
        @(negedge clk);
        csr_wr = '0;
    endtask

    task automatic program_bases();
        csr_write(`SPL_CSR_GROUP, `SPL_DSM_BASEH, rand_word());
        csr_write(`SPL_CSR_GROUP, `SPL_DSM_BASEL, rand_word());
        csr_write(`AFU_CSR_GROUP, `AFU_DSM_BASEH, rand_word());
        csr_write(`AFU_CSR_GROUP, `AFU_DSM_BASEL, rand_word());
        csr_write(`SPL_CSR_GROUP, `SPL_CTX_BASEH, rand_word());
        csr_write(`SPL_CSR_GROUP, `SPL_CTX_BASEL, rand_word());
    endtask

    task automatic wait_sent(input int target);
        int n;
        n = 0;
        while (sent_cnt < target) begin
            @(negedge clk);
            n++;
            if (n > 200) fail_with("Timeout waiting for memory writes");
        end
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (spl_q.size() != 0 || afu_q.size() != 0 || ctx_q.size() != 0
               || sent_cnt != ret_cnt) begin
            @(negedge clk);
            n++;
            if (n > 400) fail_with("Timeout waiting for expected writes and credits");
        end
    endtask

    always @(posedge clk) begin : monitor
        mem_wr_req_t exp;
        logic        hit;
        hit = 1'b0;
        exp = '0;
        if (credit_ret) ret_cnt <= ret_cnt + 1;
        if (reset_n && mem_wr_valid) begin
            sent_cnt <= sent_cnt + 1;
            if (mem_wr.src == SRC_SPL_DSM && spl_q.size() != 0) begin
                exp = spl_q.pop_front();
                hit = 1'b1;
            end else if (mem_wr.src == SRC_AFU_DSM && afu_q.size() != 0) begin
                exp = afu_q.pop_front();
                hit = 1'b1;
            end else if (mem_wr.src == SRC_CTX && ctx_q.size() != 0) begin
                exp = ctx_q.pop_front();
                hit = 1'b1;
            end
            if (!hit) fail_with("Memory write appeared that no CSR write asked for");
            check("mem_wr", 128'(mem_wr), 128'(exp));
        end
    end

    // Returns each used credit after a short random delay
    always @(negedge clk) begin : responder
        credit_ret <= 1'b0;
        if (reset_n && !credit_hold && sent_cnt > ret_cnt) begin
            if (ret_wait == 0) begin
                credit_ret <= 1'b1;
                ret_rng = lcg_step(ret_rng);
                ret_wait = int'(ret_rng[17:16]);
            end else begin
                ret_wait = ret_wait - 1;
            end
        end
    end

    initial begin : stimulus
        int sent0;
        reset_n     = 1'b0;
        csr_wr      = '0;
        credit_hold = 1'b0;
        repeat (4) @(negedge clk);
        reset_n = 1'b1;
        check("mem_wr_valid", 128'(mem_wr_valid), 128'(0));
        check("spl_reset", 128'(spl_reset), 128'(0));
        for (int i = 0; i < 4; i++) begin
            csr_write(`SPL_CSR_GROUP, `SPL_CTRL, rand_word());
            csr_write(`SPL_CSR_GROUP, `SPL_SCRATCH, rand_word());
            csr_write(`AFU_CSR_GROUP, `AFU_CMD_OPCODE, rand_word());
            csr_write(`AFU_CSR_GROUP, `AFU_SCRATCH, rand_word());
            program_bases();
            wait_idle();
        end
        credit_hold <= 1'b1;
        sent0 = sent_cnt;
        program_bases();
        program_bases();
        wait_sent(sent0 + `SPL_WR_CREDITS);
        repeat (16) @(negedge clk);  // Nothing more may leave without credits
        check("writes without credit return", 128'(sent_cnt), 128'(sent0 + `SPL_WR_CREDITS));
        credit_hold <= 1'b0;
        wait_idle();
        csr_write(8'h11, `SPL_DSM_BASEL, rand_word());
        csr_write(`SPL_CSR_GROUP, 6'd10, rand_word());
        csr_write(`AFU_CSR_GROUP, 6'd20, rand_word());
        csr_write(8'h8b, `AFU_CMD_OPCODE, rand_word());
        csr_write(`SPL_CSR_GROUP, `SPL_CTRL, 32'h3);
        check("spl_reset", 128'(spl_reset), 128'(1));
        check("spl_enable", 128'(spl_enable), 128'(1));
        @(negedge clk);
        check("spl_reset", 128'(spl_reset), 128'(0));
        program_bases();
        wait_idle();
        // Low halves alone use a cleared DSM high half and the kept context high half
        csr_write(`SPL_CSR_GROUP, `SPL_DSM_BASEL, rand_word());
        csr_write(`AFU_CSR_GROUP, `AFU_DSM_BASEL, rand_word());
        csr_write(`SPL_CSR_GROUP, `SPL_CTX_BASEL, rand_word());
        wait_idle();
        $display("test passed");
        $finish;
    end

endmodule

//--- spl_top.sv
module spl_top
    import spl_csr_pkg::*;
    import spl_mem_pkg::*;
(
    input  logic        clk,
    input  logic        reset_n,
    input  csr_wr_t     csr_wr,
    output logic        spl_reset,
    output logic        spl_enable,
    output logic        mem_wr_valid,
    output mem_wr_req_t mem_wr,
    input  logic        credit_ret
);

    logic              spl_dsm_valid;
    logic [31:0]       spl_dsm_base;
    spl_dsm_rec_t      spl_dsm_rec;
    logic              spl_dsm_done;
    logic              afu_dsm_valid;
    logic [31:0]       afu_dsm_base;
    afu_dsm_rec_t      afu_dsm_rec;
    logic              afu_dsm_done;
    logic              ctx_valid;
    logic [31:0]       ctx_base;
    ctx_hdr_rec_t      ctx_rec;
    logic              ctx_done;
    logic [2:0]        wr_req_valid;
    mem_wr_req_t [2:0] wr_req;
    logic [2:0]        wr_grant;

    csr_file u_csr_file (
        .clk           (clk),
        .reset_n       (reset_n),
        .csr_wr        (csr_wr),
        .spl_reset     (spl_reset),
        .spl_enable    (spl_enable),
        .spl_dsm_valid (spl_dsm_valid),
        .spl_dsm_base  (spl_dsm_base),
        .spl_dsm_rec   (spl_dsm_rec),
        .spl_dsm_done  (spl_dsm_done),
        .afu_dsm_valid (afu_dsm_valid),
        .afu_dsm_base  (afu_dsm_base),
        .afu_dsm_rec   (afu_dsm_rec),
        .afu_dsm_done  (afu_dsm_done),
        .ctx_valid     (ctx_valid),
        .ctx_base      (ctx_base),
        .ctx_rec       (ctx_rec),
        .ctx_done      (ctx_done)
    );

    // Writer index matches the source tag value
    base_writer #(.payload_t(spl_dsm_rec_t)) u_spl_dsm_writer (
        .clk (clk), .reset_n (reset_n), .base_valid (spl_dsm_valid),
        .base (spl_dsm_base), .payload (spl_dsm_rec), .src (SRC_SPL_DSM),
        .done (spl_dsm_done), .req_valid (wr_req_valid[0]), .req (wr_req[0]),
        .grant (wr_grant[0])
    );

    base_writer #(.payload_t(afu_dsm_rec_t)) u_afu_dsm_writer (
        .clk (clk), .reset_n (reset_n), .base_valid (afu_dsm_valid),
        .base (afu_dsm_base), .payload (afu_dsm_rec), .src (SRC_AFU_DSM),
        .done (afu_dsm_done), .req_valid (wr_req_valid[1]), .req (wr_req[1]),
        .grant (wr_grant[1])
    );

    base_writer #(.payload_t(ctx_hdr_rec_t)) u_ctx_writer (
        .clk (clk), .reset_n (reset_n), .base_valid (ctx_valid),
        .base (ctx_base), .payload (ctx_rec), .src (SRC_CTX),
        .done (ctx_done), .req_valid (wr_req_valid[2]), .req (wr_req[2]),
        .grant (wr_grant[2])
    );

    wr_arbiter u_wr_arbiter (
        .clk          (clk),
        .reset_n      (reset_n),
        .req_valid    (wr_req_valid),
        .req          (wr_req),
        .grant        (wr_grant),
        .mem_wr_valid (mem_wr_valid),
        .mem_wr       (mem_wr),
        .credit_ret   (credit_ret)
    );

endmodule

//--- wr_arbiter.sv
`include "spl_settings.svh"

module wr_arbiter
    import spl_mem_pkg::*;
(
    input  logic              clk,
    input  logic              reset_n,
    input  logic [2:0]        req_valid,
    input  mem_wr_req_t [2:0] req,
    output logic [2:0]        grant,
    output logic              mem_wr_valid,
    output mem_wr_req_t       mem_wr,
    input  logic              credit_ret
);

    localparam int CREDIT_W = $clog2(`SPL_WR_CREDITS + 1);
    localparam logic [CREDIT_W-1:0] CREDIT_MAX = CREDIT_W'(`SPL_WR_CREDITS);

    logic [CREDIT_W-1:0] credits;
    logic [1:0]          last;  // Source granted most recently
    logic [1:0]          sel;
    logic                found;
    logic                send;

    // Search starts one past the last winner so every source gets a turn
    always_comb begin : pick
        logic [1:0] idx;
        found = 1'b0;
        sel   = last;
        for (int i = 1; i <= 3; i++) begin
            idx = 2'((int'(last) + i) % 3);
            if (!found && req_valid[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    assign send  = found && (credits != '0);
    assign grant = send ? (3'b001 << sel) : 3'b000;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            credits      <= CREDIT_MAX;
            last         <= 2'd2;  // Source 0 wins the first round
            mem_wr_valid <= 1'b0;
        end else begin
            mem_wr_valid <= send;
            if (send) begin
                last <= sel;
            end
            case ({send, credit_ret})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            mem_wr <= req[sel];
        end
    end

    // The memory side must not return more credits than it was given
    a_credit_range: assert property (@(posedge clk) disable iff (!reset_n)
        credits <= CREDIT_MAX);

endmodule

//--- base_writer.sv
module base_writer
    import spl_mem_pkg::*;
#(
    parameter type payload_t = logic [63:0]
)
(
    input  logic        clk,
    input  logic        reset_n,
    input  logic        base_valid,
    input  logic [31:0] base,
    input  payload_t    payload,
    input  mem_src_e    src,
    output logic        done,
    output logic        req_valid,
    output mem_wr_req_t req,
    input  logic        grant
);

    mem_wr_req_t req_q;
    payload_t    payload_q;
    logic [31:0] base_q;
    mem_src_e    src_q;

    // Take the base as soon as the single slot is free
    assign done = base_valid && !req_valid;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            req_valid <= 1'b0;
        end else if (done) begin
            req_valid <= 1'b1;
        end else if (grant) begin
            req_valid <= 1'b0;  // Arbiter has copied the request out
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            base_q    <= base;
            payload_q <= payload;
            src_q     <= src;
        end
    end

    // The record is packed straight into the data word of the request
    always_comb begin
        req_q      = '0;
        req_q.addr = base_q;
        req_q.data = payload_q;
        req_q.src  = src_q;
    end

    assign req = req_q;

    // The arbiter must never grant an empty writer
    a_grant_when_pending: assert property (@(posedge clk) disable iff (!reset_n)
        grant |-> req_valid);

endmodule

//--- csr_file.sv
`include "spl_settings.svh"

module csr_file
    import spl_csr_pkg::*;
(
    input  logic         clk,
    input  logic         reset_n,
    input  csr_wr_t      csr_wr,
    output logic         spl_reset,
    output logic         spl_enable,
    output logic         spl_dsm_valid,
    output logic [31:0]  spl_dsm_base,
    output spl_dsm_rec_t spl_dsm_rec,
    input  logic         spl_dsm_done,
    output logic         afu_dsm_valid,
    output logic [31:0]  afu_dsm_base,
    output afu_dsm_rec_t afu_dsm_rec,
    input  logic         afu_dsm_done,
    output logic         ctx_valid,
    output logic [31:0]  ctx_base,
    output ctx_hdr_rec_t ctx_rec,
    input  logic         ctx_done
);

    logic        spl_hit;
    logic        afu_hit;
    logic [5:0]  offset;
    logic [5:0]  spl_dsm_hi;
    logic [5:0]  afu_dsm_hi;
    logic [5:0]  ctx_hi;
    logic [31:0] spl_scratch;
    logic [31:0] afu_scratch;
    logic [31:0] afu_opcode;
    logic [7:0]  spl_dsm_cnt;
    logic [31:0] ctx_seq;
    logic        spl_dsm_load;
    logic        afu_dsm_load;
    logic        ctx_load;
    logic [2:0]  valid_vec;
    logic [2:0]  done_vec;

    assign spl_hit = csr_wr.valid && (csr_wr.addr[13:6] == `SPL_CSR_GROUP);
    assign afu_hit = csr_wr.valid && (csr_wr.addr[13:6] == `AFU_CSR_GROUP);
    assign offset  = csr_wr.addr[5:0];

    // A low-half write starts a handover unless the previous base is still pending
    assign spl_dsm_load = spl_hit && (offset == `SPL_DSM_BASEL) && !spl_dsm_valid;
    assign ctx_load     = spl_hit && (offset == `SPL_CTX_BASEL) && !ctx_valid;
    assign afu_dsm_load = afu_hit && (offset == `AFU_DSM_BASEL) && !afu_dsm_valid;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            spl_reset     <= 1'b0;
            spl_enable    <= 1'b0;
            spl_dsm_valid <= 1'b0;
            afu_dsm_valid <= 1'b0;
            ctx_valid     <= 1'b0;
            spl_dsm_hi    <= '0;
            afu_dsm_hi    <= '0;
            ctx_hi        <= '0;
            spl_scratch   <= '0;
            afu_scratch   <= '0;
            afu_opcode    <= '0;
            spl_dsm_cnt   <= '0;
            ctx_seq       <= '0;
        end else begin
            spl_reset <= 1'b0;  // Pulse lasts one cycle
            if (spl_dsm_done) begin
                spl_dsm_valid <= 1'b0;
                spl_dsm_hi    <= '0;
            end
            if (afu_dsm_done) begin
                afu_dsm_valid <= 1'b0;
                afu_dsm_hi    <= '0;
            end
            if (ctx_done) begin
                ctx_valid <= 1'b0;
            end
            if (spl_dsm_load) begin
                spl_dsm_valid <= 1'b1;
                spl_dsm_cnt   <= spl_dsm_cnt + 8'd1;
            end
            if (afu_dsm_load) begin
                afu_dsm_valid <= 1'b1;
            end
            if (ctx_load) begin
                ctx_valid <= 1'b1;
                ctx_seq   <= ctx_seq + 32'd1;
            end
            if (spl_hit) begin
                case (offset)
                    `SPL_DSM_BASEH: spl_dsm_hi  <= csr_wr.data[5:0];
                    `SPL_CTX_BASEH: ctx_hi      <= csr_wr.data[5:0];
                    `SPL_SCRATCH:   spl_scratch <= csr_wr.data;
                    `SPL_CTRL: begin
                        spl_reset  <= csr_wr.data[0];
                        spl_enable <= csr_wr.data[1];
                    end
                    default: ;
                endcase
            end
            if (afu_hit) begin
                case (offset)
                    `AFU_DSM_BASEH:  afu_dsm_hi  <= csr_wr.data[5:0];
                    `AFU_CMD_OPCODE: afu_opcode  <= csr_wr.data;
                    `AFU_SCRATCH:    afu_scratch <= csr_wr.data;
                    default: ;
                endcase
            end
        end
    end

    // Base and record are frozen together so the writer sees one consistent snapshot
    always_ff @(posedge clk) begin
        if (spl_dsm_load) begin
            spl_dsm_base           <= {spl_dsm_hi, csr_wr.data[31:6]};
            spl_dsm_rec.rsvd       <= '0;
            spl_dsm_rec.enable     <= spl_enable;
            spl_dsm_rec.prog_count <= spl_dsm_cnt + 8'd1;
            spl_dsm_rec.scratch    <= spl_scratch;
        end
        if (afu_dsm_load) begin
            afu_dsm_base        <= {afu_dsm_hi, csr_wr.data[31:6]};
            afu_dsm_rec.opcode  <= afu_opcode;
            afu_dsm_rec.scratch <= afu_scratch;
        end
        if (ctx_load) begin
            ctx_base          <= {ctx_hi, csr_wr.data[31:6]};
            ctx_rec.rsvd      <= '0;
            ctx_rec.enable    <= spl_enable;
            ctx_rec.seq_count <= ctx_seq + 32'd1;
        end
    end

    assign valid_vec = {ctx_valid, afu_dsm_valid, spl_dsm_valid};
    assign done_vec  = {ctx_done, afu_dsm_done, spl_dsm_done};

    // A pending base only drops once its writer has taken it
    a_valid_until_done: assert property (@(posedge clk) disable iff (!reset_n)
        $past(reset_n) |-> (($past(valid_vec) & ~valid_vec & ~$past(done_vec)) == 3'b000));

endmodule

//--- spl_mem_pkg.sv
`include "spl_settings.svh"

package spl_mem_pkg;

    // Which register group a memory write came from
    typedef enum logic [`SPL_SRC_TAG_W-1:0] {
        SRC_SPL_DSM = 2'd0,
        SRC_AFU_DSM = 2'd1,
        SRC_CTX     = 2'd2
    } mem_src_e;

    localparam int MEM_ADDR_BITS = 32;  // Cache-line address, not a byte address
    localparam int MEM_DATA_BITS = 64;
    localparam int NUM_SRC       = 3;

    // One write on the outgoing memory port
    typedef struct packed {
        logic [MEM_ADDR_BITS-1:0] addr;
        logic [MEM_DATA_BITS-1:0] data;
        mem_src_e                 src;
    } mem_wr_req_t;

    typedef logic [NUM_SRC-1:0] src_mask_t;

    localparam int MEM_WR_REQ_BITS = $bits(mem_wr_req_t);

endpackage

//--- spl_csr_pkg.sv
package spl_csr_pkg;

    // One host write into the CSR space, no read path
    typedef struct packed {
        logic        valid;
        logic [13:0] addr;  // Bits 13:6 group, bits 5:0 offset
        logic [31:0] data;
    } csr_wr_t;

    // System status record written to the DSM base
    typedef struct packed {
        logic [22:0] rsvd;
        logic        enable;
        logic [7:0]  prog_count;  // Number of DSM base programs so far
        logic [31:0] scratch;
    } spl_dsm_rec_t;

    // Accelerator status record written to the accelerator DSM base
    typedef struct packed {
        logic [31:0] opcode;
        logic [31:0] scratch;
    } afu_dsm_rec_t;

    // Context header written to the context base
    typedef struct packed {
        logic [30:0] rsvd;
        logic        enable;
        logic [31:0] seq_count;
    } ctx_hdr_rec_t;

    // Every record fills exactly one 64-bit data word of a memory write
    localparam int REC_BITS = 64;

    typedef logic [REC_BITS-1:0] rec_word_t;

    localparam int SPL_DSM_REC_BITS = $bits(spl_dsm_rec_t);
    localparam int AFU_DSM_REC_BITS = $bits(afu_dsm_rec_t);
    localparam int CTX_HDR_REC_BITS = $bits(ctx_hdr_rec_t);

endpackage

//--- spl_settings.svh
`ifndef SPL_SETTINGS_SVH
`define SPL_SETTINGS_SVH

// Address bits 13:6 select the register group
`define SPL_CSR_GROUP   8'h10
`define AFU_CSR_GROUP   8'h8a

`define SPL_DSM_BASEL   6'd0
`define SPL_DSM_BASEH   6'd1
`define SPL_CTX_BASEL   6'd2
`define SPL_CTX_BASEH   6'd3
`define SPL_CTRL        6'd4
`define SPL_SCRATCH     6'd63

`define AFU_DSM_BASEL   6'd0
`define AFU_DSM_BASEH   6'd1
`define AFU_CMD_OPCODE  6'd15
`define AFU_SCRATCH     6'd63

`define SPL_WR_CREDITS  4   // Credits held by the memory port after reset
`define SPL_SRC_TAG_W   2

`endif
